/* common/revive_pkg.sv */
// Widths, encodings and pipeline stage structs shared by all modules of the core
`default_nettype none

package revive_pkg;

	localparam int W_DATA    = 32;
	localparam int W_ADDR    = 32;
	localparam int W_REGADDR = 5;

	// addi x0, x0, 0
	localparam logic [W_DATA-1:0] NOP_INSTR = 32'h0000_0013;

	// ================================================
	// Encodings
	// ================================================

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic {SRCA_RS1, SRCA_ZERO} alusrc_a_e;
	typedef enum logic {SRCB_RS2, SRCB_IMM} alusrc_b_e;

	// MEM_NONE must stay zero so an all-zero struct is a bubble
	typedef enum logic [3:0] {
		MEM_NONE, MEM_LW, MEM_LH, MEM_LHU, MEM_LB,
		MEM_LBU, MEM_SW, MEM_SH, MEM_SB
	} mem_op_e;

	typedef enum logic [1:0] {HTRANS_IDLE = 2'b00, HTRANS_NONSEQ = 2'b10} htrans_e;

	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} hsize_e;

	// ================================================
	// Stage structs
	// ================================================

	// D to X
	typedef struct packed {
		logic [W_REGADDR-1:0] rs1;
		logic [W_REGADDR-1:0] rs2;
		logic [W_REGADDR-1:0] rd;
		logic [W_DATA-1:0]    imm;
		alu_op_e              alu_op;
		alusrc_a_e            alusrc_a;
		alusrc_b_e            alusrc_b;
		mem_op_e              mem_op;
	} dx_ctrl_t;

	// X to M, result doubles as the data address
	typedef struct packed {
		logic [W_REGADDR-1:0] rd;
		logic [W_REGADDR-1:0] rs2;
		logic [W_DATA-1:0]    result;
		logic [W_DATA-1:0]    store_data;
		mem_op_e              mem_op;
	} xm_t;

	// M to W, rd of zero writes nothing
	typedef struct packed {
		logic [W_REGADDR-1:0] rd;
		logic [W_DATA-1:0]    result;
	} wb_t;

	function automatic logic is_load(input mem_op_e op);
		return op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
	endfunction

	function automatic logic is_store(input mem_op_e op);
		return op inside {MEM_SW, MEM_SH, MEM_SB};
	endfunction

endpackage

`default_nettype wire

/* core/revive_fetch.sv */
// Fetch stage: word address counter, bus request and one-word skid slot in front of decode
`timescale 1ns/100ps
`default_nettype none

module revive_fetch #(
	parameter logic [revive_pkg::W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          hready_i,
	input  wire logic                          fetch_grant_i,
	input  wire logic                          fetch_rdata_valid_i,
	input  wire logic [revive_pkg::W_DATA-1:0] rdata_i,
	input  wire logic                          d_hold_i,
	output logic                               fetch_req_o,
	output logic      [revive_pkg::W_ADDR-1:0] fetch_addr_o,
	output logic      [revive_pkg::W_DATA-1:0] instr_o,
	output logic                               instr_valid_o
);
	import revive_pkg::*;

	logic              fetch_en;
	logic              pending;
	logic              skid_valid;
	logic [W_DATA-1:0] skid_word;
	logic              skid_load;

	// A word arriving while decode holds needs a free slot next cycle
	assign fetch_req_o = fetch_en && !skid_valid && !(pending && d_hold_i);

	// Skid word is older than anything on the bus
	assign instr_o       = skid_valid ? skid_word : rdata_i;
	assign instr_valid_o = skid_valid || fetch_rdata_valid_i;

	// Fill when decode takes the slot, or when decode holds with the slot empty
	assign skid_load = fetch_rdata_valid_i && (skid_valid ? !d_hold_i : d_hold_i);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_en     <= 1'b0;
			pending      <= 1'b0;
			skid_valid   <= 1'b0;
			fetch_addr_o <= RESET_VECTOR;
		end else begin
			fetch_en <= 1'b1;
			if (hready_i) begin
				// At most one fetch in its data phase
				pending <= fetch_grant_i;
				if (fetch_grant_i) begin
					fetch_addr_o <= fetch_addr_o + W_ADDR'(4);
				end
				if (d_hold_i) begin
					skid_valid <= skid_valid || fetch_rdata_valid_i;
				end else begin
					skid_valid <= skid_valid && fetch_rdata_valid_i;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hready_i && skid_load) begin
			skid_word <= rdata_i;
		end
	end

endmodule

`default_nettype wire

/* core/revive_decode.sv */
// Decode stage: turns an RV32I word into the execute control struct and register read addresses
`timescale 1ns/100ps
`default_nettype none

module revive_decode (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             hold_i,
	input  wire logic [revive_pkg::W_DATA-1:0]    instr_i,
	input  wire logic                             instr_valid_i,
	output logic      [revive_pkg::W_REGADDR-1:0] rs1_o,
	output logic      [revive_pkg::W_REGADDR-1:0] rs2_o,
	output revive_pkg::dx_ctrl_t                  dx_o
);
	import revive_pkg::*;

	typedef enum logic [6:0] {
		OPC_LOAD  = 7'b0000011,
		OPC_OPIMM = 7'b0010011,
		OPC_STORE = 7'b0100011,
		OPC_OP    = 7'b0110011,
		OPC_LUI   = 7'b0110111
	} opcode_e;

	logic [W_DATA-1:0] d_word;

	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	// Anything not matched stays an all-zero bubble
	function automatic dx_ctrl_t decode_instr(input logic [W_DATA-1:0] instr);
		dx_ctrl_t          d;
		logic [2:0]        f3;
		logic [6:0]        f7;
		logic [W_DATA-1:0] imm_i;
		logic [W_DATA-1:0] imm_s;
		logic              shift_ok;
		f3       = instr[14:12];
		f7       = instr[31:25];
		imm_i    = {{20{instr[31]}}, instr[31:20]};
		imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		shift_ok = (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b101);
		d        = '0;
		case (instr[6:0])
			OPC_LUI: begin
				d.rd       = instr[11:7];
				d.imm      = {instr[31:12], 12'h000};
				d.alusrc_a = SRCA_ZERO;
				d.alusrc_b = SRCB_IMM;
			end
			OPC_OPIMM: begin
				if (!(f3 == 3'b001 || f3 == 3'b101) || shift_ok) begin
					d.rs1      = instr[19:15];
					d.rd       = instr[11:7];
					d.imm      = imm_i;
					d.alusrc_b = SRCB_IMM;
					// Only shifts take bit 30 as a modifier here
					d.alu_op   = alu_from_funct3(f3, f3 == 3'b101 && instr[30]);
				end
			end
			OPC_OP: begin
				if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
					d.rs1    = instr[19:15];
					d.rs2    = instr[24:20];
					d.rd     = instr[11:7];
					d.alu_op = alu_from_funct3(f3, instr[30]);
				end
			end
			OPC_LOAD: begin
				case (f3)
					3'b000:  d.mem_op = MEM_LB;
					3'b001:  d.mem_op = MEM_LH;
					3'b010:  d.mem_op = MEM_LW;
					3'b100:  d.mem_op = MEM_LBU;
					3'b101:  d.mem_op = MEM_LHU;
					default: d.mem_op = MEM_NONE;
				endcase
				if (d.mem_op != MEM_NONE) begin
					d.rs1      = instr[19:15];
					d.rd       = instr[11:7];
					d.imm      = imm_i;
					d.alusrc_b = SRCB_IMM;
				end
			end
			OPC_STORE: begin
				case (f3)
					3'b000:  d.mem_op = MEM_SB;
					3'b001:  d.mem_op = MEM_SH;
					3'b010:  d.mem_op = MEM_SW;
					default: d.mem_op = MEM_NONE;
				endcase
				if (d.mem_op != MEM_NONE) begin
					d.rs1      = instr[19:15];
					d.rs2      = instr[24:20];
					d.imm      = imm_s;
					d.alusrc_b = SRCB_IMM;
				end
			end
			default: d = '0;
		endcase
		return d;
	endfunction

	// Empty slot decodes as a NOP
	assign d_word = instr_valid_i ? instr_i : NOP_INSTR;
	assign rs1_o  = d_word[19:15];
	assign rs2_o  = d_word[24:20];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_o <= decode_instr(NOP_INSTR);
		end else if (!hold_i) begin
			dx_o <= decode_instr(d_word);
		end
	end

endmodule

`default_nettype wire

/* core/revive_regfile.sv */
// Integer register file with one write port and two registered read ports
`timescale 1ns/100ps
`default_nettype none

module revive_regfile (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             hold_i,
	input  wire logic [revive_pkg::W_REGADDR-1:0] raddr1_i,
	input  wire logic [revive_pkg::W_REGADDR-1:0] raddr2_i,
	output logic      [revive_pkg::W_DATA-1:0]    rdata1_o,
	output logic      [revive_pkg::W_DATA-1:0]    rdata2_o,
	input  wire revive_pkg::wb_t                  wb_i
);
	import revive_pkg::*;

	logic [W_DATA-1:0]    regs [1:31];
	logic [W_REGADDR-1:0] raddr1_q;
	logic [W_REGADDR-1:0] raddr2_q;
	logic [W_REGADDR-1:0] ra1;
	logic [W_REGADDR-1:0] ra2;

	// Re-read the instruction now in X while the pipe holds
	assign ra1 = hold_i ? raddr1_q : raddr1_i;
	assign ra2 = hold_i ? raddr2_q : raddr2_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raddr1_q <= '0;
			raddr2_q <= '0;
		end else begin
			raddr1_q <= ra1;
			raddr2_q <= ra2;
		end
	end

	always_ff @(posedge clk) begin
		rdata1_o <= (ra1 == '0) ? '0 : regs[ra1];
		rdata2_o <= (ra2 == '0) ? '0 : regs[ra2];
		if (wb_i.rd != '0) begin
			regs[wb_i.rd] <= wb_i.result;
		end
	end

endmodule

`default_nettype wire

/* core/revive_execute.sv */
// Execute stage: operand bypass, ALU, load-use detection and the data bus request
`timescale 1ns/100ps
`default_nettype none

module revive_execute (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          hready_i,
	input  wire revive_pkg::dx_ctrl_t          dx_i,
	input  wire logic [revive_pkg::W_DATA-1:0] rdata1_i,
	input  wire logic [revive_pkg::W_DATA-1:0] rdata2_i,
	input  wire revive_pkg::wb_t               wb_i,
	output logic                               x_stall_o,
	output logic                               dreq_o,
	output logic      [revive_pkg::W_ADDR-1:0] dreq_addr_o,
	output logic                               dreq_write_o,
	output revive_pkg::hsize_e                 dreq_size_o,
	output revive_pkg::xm_t                    xm_o
);
	import revive_pkg::*;

	// Write that landed last cycle and is not yet in the regfile read data
	wb_t               wb_q;
	logic [W_DATA-1:0] rs1_val;
	logic [W_DATA-1:0] rs2_val;
	logic [W_DATA-1:0] op_a;
	logic [W_DATA-1:0] op_b;
	logic [W_DATA-1:0] alu_result;

	// Youngest producer wins
	function automatic logic [W_DATA-1:0] fwd(
		input logic [W_REGADDR-1:0] rs,
		input logic [W_DATA-1:0]    rf_val,
		input xm_t                  m,
		input wb_t                  w,
		input wb_t                  w_prev
	);
		return (rs == '0)          ? '0 :
			(m.rd == rs)           ? m.result :
			(w.rd == rs)           ? w.result :
			(w_prev.rd == rs)      ? w_prev.result : rf_val;
	endfunction

	// ================================================
	// Operands and ALU
	// ================================================

	assign rs1_val = fwd(dx_i.rs1, rdata1_i, xm_o, wb_i, wb_q);
	assign rs2_val = fwd(dx_i.rs2, rdata2_i, xm_o, wb_i, wb_q);
	assign op_a    = (dx_i.alusrc_a == SRCA_ZERO) ? '0 : rs1_val;
	assign op_b    = (dx_i.alusrc_b == SRCB_IMM) ? dx_i.imm : rs2_val;

	always_comb begin
		case (dx_i.alu_op)
			ALU_SUB:  alu_result = op_a - op_b;
			ALU_SLL:  alu_result = op_a << op_b[4:0];
			ALU_SLT:  alu_result = {{(W_DATA-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_result = {{(W_DATA-1){1'b0}}, op_a < op_b};
			ALU_XOR:  alu_result = op_a ^ op_b;
			ALU_SRL:  alu_result = op_a >> op_b[4:0];
			ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
			ALU_OR:   alu_result = op_a | op_b;
			ALU_AND:  alu_result = op_a & op_b;
			default:  alu_result = op_a + op_b;
		endcase
	end

	// Load in M feeding either source of X
	assign x_stall_o = is_load(xm_o.mem_op) && xm_o.rd != '0 &&
		(xm_o.rd == dx_i.rs1 || xm_o.rd == dx_i.rs2);

	// ================================================
	// Data request
	// ================================================

	assign dreq_o       = dx_i.mem_op != MEM_NONE && !x_stall_o;
	assign dreq_addr_o  = alu_result;
	assign dreq_write_o = is_store(dx_i.mem_op);

	always_comb begin
		case (dx_i.mem_op)
			MEM_LW, MEM_SW:          dreq_size_o = HSIZE_WORD;
			MEM_LH, MEM_LHU, MEM_SH: dreq_size_o = HSIZE_HALF;
			default:                 dreq_size_o = HSIZE_BYTE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xm_o <= '0;
			wb_q <= '0;
		end else if (hready_i) begin
			wb_q <= wb_i;
			if (x_stall_o) begin
				// Bubble into M while X waits for the load
				xm_o <= '0;
			end else begin
				xm_o.rd         <= dx_i.rd;
				xm_o.rs2        <= dx_i.rs2;
				xm_o.result     <= alu_result;
				xm_o.store_data <= rs2_val;
				xm_o.mem_op     <= dx_i.mem_op;
			end
		end
	end

endmodule

`default_nettype wire

/* core/revive_mem_stage.sv */
// Memory stage: store lane replication and load alignment into the write-back result
`timescale 1ns/100ps
`default_nettype none

module revive_mem_stage (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          hready_i,
	input  wire revive_pkg::xm_t               xm_i,
	input  wire logic [revive_pkg::W_DATA-1:0] load_data_i,
	output logic      [revive_pkg::W_DATA-1:0] wdata_o,
	output revive_pkg::wb_t                    wb_o
);
	import revive_pkg::*;

	logic [W_DATA-1:0] rdata_sh;
	logic [W_DATA-1:0] result;

	// Narrow stores drive every lane
	always_comb begin
		case (xm_i.mem_op)
			MEM_SW:  wdata_o = xm_i.store_data;
			MEM_SH:  wdata_o = {2{xm_i.store_data[15:0]}};
			MEM_SB:  wdata_o = {4{xm_i.store_data[7:0]}};
			default: wdata_o = '0;
		endcase
	end

	// Bring the addressed byte lane down to bit 0
	assign rdata_sh = load_data_i >> {xm_i.result[1:0], 3'b000};

	always_comb begin
		case (xm_i.mem_op)
			MEM_LW:  result = rdata_sh;
			MEM_LH:  result = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
			MEM_LHU: result = {16'h0000, rdata_sh[15:0]};
			MEM_LB:  result = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
			MEM_LBU: result = {24'h00_0000, rdata_sh[7:0]};
			default: result = xm_i.result;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_o <= '0;
		end else if (hready_i) begin
			wb_o.rd     <= xm_i.rd;
			wb_o.result <= result;
		end
	end

endmodule

`default_nettype wire

/* src/revive_core.sv */
// Core top level: AHB-lite master with data-over-fetch priority and the five-stage pipeline
`timescale 1ns/100ps
`default_nettype none

module revive_core #(
	parameter logic [revive_pkg::W_ADDR-1:0] RESET_VECTOR = '0
) (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          hready_i,
	input  wire logic [revive_pkg::W_DATA-1:0] hrdata_i,
	output logic      [revive_pkg::W_ADDR-1:0] haddr_o,
	output logic                               hwrite_o,
	output revive_pkg::htrans_e                htrans_o,
	output revive_pkg::hsize_e                 hsize_o,
	output logic      [2:0]                    hburst_o,
	output logic      [3:0]                    hprot_o,
	output logic                               hmastlock_o,
	output logic      [revive_pkg::W_DATA-1:0] hwdata_o
);
	import revive_pkg::*;

	typedef enum logic [1:0] {DP_IDLE, DP_FETCH, DP_LOAD, DP_STORE} dphase_e;

	dphase_e              dphase_q;
	logic                 fetch_req;
	logic                 fetch_grant;
	logic                 fetch_rdata_valid;
	logic [W_ADDR-1:0]    fetch_addr;
	logic [W_DATA-1:0]    instr;
	logic                 instr_valid;
	logic                 x_stall;
	logic                 pipe_hold;
	logic [W_REGADDR-1:0] rs1;
	logic [W_REGADDR-1:0] rs2;
	logic [W_DATA-1:0]    rdata1;
	logic [W_DATA-1:0]    rdata2;
	logic                 dreq;
	logic [W_ADDR-1:0]    dreq_addr;
	logic                 dreq_write;
	hsize_e               dreq_size;
	logic [W_DATA-1:0]    load_data;
	logic [W_DATA-1:0]    wdata;
	dx_ctrl_t             dx;
	xm_t                  xm;
	wb_t                  wb;

	// ================================================
	// AHB-lite master
	// ================================================

	// Single transfers, privileged non-cacheable data, never locked
	assign hburst_o    = 3'b000;
	assign hprot_o     = 4'b0011;
	assign hmastlock_o = 1'b0;

	assign pipe_hold   = !hready_i || x_stall;
	assign fetch_grant = fetch_req && !dreq && hready_i;

	always_comb begin
		if (dreq) begin
			htrans_o = HTRANS_NONSEQ;
			haddr_o  = dreq_addr;
			hsize_o  = dreq_size;
			hwrite_o = dreq_write;
		end else if (fetch_req) begin
			htrans_o = HTRANS_NONSEQ;
			haddr_o  = fetch_addr;
			hsize_o  = HSIZE_WORD;
			hwrite_o = 1'b0;
		end else begin
			htrans_o = HTRANS_IDLE;
			haddr_o  = '0;
			hsize_o  = HSIZE_WORD;
			hwrite_o = 1'b0;
		end
	end

	// Kind of transfer now in its data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dphase_q <= DP_IDLE;
		end else if (hready_i) begin
			if (dreq) begin
				dphase_q <= dreq_write ? DP_STORE : DP_LOAD;
			end else if (fetch_req) begin
				dphase_q <= DP_FETCH;
			end else begin
				dphase_q <= DP_IDLE;
			end
		end
	end

	assign fetch_rdata_valid = dphase_q == DP_FETCH && hready_i;
	assign load_data         = (dphase_q == DP_LOAD) ? hrdata_i : '0;
	assign hwdata_o          = (dphase_q == DP_STORE) ? wdata : '0;

	// ================================================
	// Pipeline stages
	// ================================================

	revive_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) i_revive_fetch (
		.clk                 (clk),
		.rst_n               (rst_n),
		.hready_i            (hready_i),
		.fetch_grant_i       (fetch_grant),
		.fetch_rdata_valid_i (fetch_rdata_valid),
		.rdata_i             (hrdata_i),
		.d_hold_i            (x_stall),
		.fetch_req_o         (fetch_req),
		.fetch_addr_o        (fetch_addr),
		.instr_o             (instr),
		.instr_valid_o       (instr_valid)
	);

	revive_decode i_revive_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.hold_i        (pipe_hold),
		.instr_i       (instr),
		.instr_valid_i (instr_valid),
		.rs1_o         (rs1),
		.rs2_o         (rs2),
		.dx_o          (dx)
	);

	revive_regfile i_revive_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.hold_i   (pipe_hold),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wb_i     (wb)
	);

	revive_execute i_revive_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.hready_i     (hready_i),
		.dx_i         (dx),
		.rdata1_i     (rdata1),
		.rdata2_i     (rdata2),
		.wb_i         (wb),
		.x_stall_o    (x_stall),
		.dreq_o       (dreq),
		.dreq_addr_o  (dreq_addr),
		.dreq_write_o (dreq_write),
		.dreq_size_o  (dreq_size),
		.xm_o         (xm)
	);

	revive_mem_stage i_revive_mem_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.hready_i    (hready_i),
		.xm_i        (xm),
		.load_data_i (load_data),
		.wdata_o     (wdata),
		.wb_o        (wb)
	);

endmodule

`default_nettype wire

/* sim/tb_revive_model.svh */
// Random RV32I program generator and reference model, included inside the core testbench
`ifndef TB_REVIVE_MODEL_SVH
`define TB_REVIVE_MODEL_SVH

typedef struct packed {
	logic [31:0] addr;
	logic [2:0]  size;
	logic [31:0] data;
} store_t;

localparam int N_RANDOM  = 200;
localparam int PROG_LEN  = 1 + 7 + N_RANDOM + 7;
localparam int MEM_WORDS = 4096;
localparam int DATA_BASE = 32'h2000;

logic [31:0] rng;
logic [31:0] bus_mem [0:MEM_WORDS-1];
logic [31:0] iss_mem [0:MEM_WORDS-1];
store_t      exp_q [$];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] rand32();
	rng = xorshift32(rng);
	return rng;
endfunction

// Only x1 to x7, so dependences are dense
function automatic logic [4:0] pick_reg();
	return 5'(1 + rand32() % 7);
endfunction

// Offset into the first 256 bytes of data, aligned to the access size
function automatic logic [11:0] mem_offset(input logic [1:0] sz);
	logic [11:0] off;
	off = 12'(rand32() % 256);
	return off & ~12'((1 << sz) - 1);
endfunction

function automatic logic [31:0] random_instr();
	logic [31:0] r;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [11:0] imm;
	r   = rand32();
	rd  = pick_reg();
	rs1 = pick_reg();
	rs2 = pick_reg();
	f3  = r[2:0];
	imm = r[31:20];
	f7  = ((f3 == 3'd0 || f3 == 3'd5) && r[19]) ? 7'h20 : 7'h00;
	case (rand32() % 10)
		0, 1, 2: return {f7, rs2, rs1, f3, rd, 7'b0110011};
		3, 4: begin
			// Shift immediates carry the funct7 field
			if (f3 == 3'd1 || f3 == 3'd5) begin
				imm = {f7, imm[4:0]};
			end
			return {imm, rs1, f3, rd, 7'b0010011};
		end
		5: return {r[31:12], rd, 7'b0110111};
		6, 7: begin
			f3 = 3'(r % 5);
			if (f3 > 3'd2) begin
				f3 = f3 + 3'd1;
			end
			imm = mem_offset(f3[1:0]);
			return {imm, 5'd8, f3, rd, 7'b0000011};
		end
		default: begin
			f3  = 3'(r % 3);
			imm = mem_offset(f3[1:0]);
			return {imm[11:5], rs2, 5'd8, f3, imm[4:0], 7'b0100011};
		end
	endcase
endfunction

task automatic gen_program();
	rng = 32'hf94e68de;
	for (int i = 0; i < MEM_WORDS; i++) begin
		bus_mem[i] = (i < DATA_BASE / 4) ? 32'h0000_0013 : rand32();
	end
	// x8 points at the data region
	bus_mem[0] = {20'h00002, 5'd8, 7'b0110111};
	for (int i = 1; i <= 7; i++) begin
		bus_mem[i] = {12'(rand32()), 5'd0, 3'b000, 5'(i), 7'b0010011};
	end
	for (int i = 8; i < 8 + N_RANDOM; i++) begin
		bus_mem[i] = random_instr();
	end
	// Final dump of x1 to x7 to 0x2104 and up
	for (int i = 1; i <= 7; i++) begin
		bus_mem[7 + N_RANDOM + i] = {7'd8, 5'(i), 5'd8, 3'b010, 5'(4 * i), 7'b0100011};
	end
endtask

function automatic logic [31:0] alu_ref(
	input logic [2:0]  f3,
	input logic        alt,
	input logic [31:0] a,
	input logic [31:0] b
);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3: return (a < b) ? 32'd1 : 32'd0;
		3'd4: return a ^ b;
		3'd5: begin
			if (alt) begin
				return $signed(a) >>> b[4:0];
			end
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// AHB drives the same value on every byte lane of a narrow write
function automatic logic [31:0] replicate_lanes(input logic [31:0] v, input logic [1:0] sz);
	case (sz)
		2'd0:    return {4{v[7:0]}};
		2'd1:    return {2{v[15:0]}};
		default: return v;
	endcase
endfunction

function automatic logic [31:0] merge_lanes(
	input logic [31:0] old,
	input logic [31:0] data,
	input logic [31:0] addr,
	input logic [1:0]  sz
);
	logic [31:0] mask;
	case (sz)
		2'd0:    mask = 32'h0000_00ff << (8 * addr[1:0]);
		2'd1:    mask = 32'h0000_ffff << (16 * addr[1]);
		default: mask = 32'hffff_ffff;
	endcase
	return (old & ~mask) | (data & mask);
endfunction

// Straight-line reference run over its own copy of memory
task automatic run_model();
	logic [31:0] x [0:31];
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] addr;
	logic [31:0] lane;
	logic [31:0] v;
	logic        wr;
	store_t      e;
	for (int i = 0; i < 32; i++) begin
		x[i] = '0;
	end
	iss_mem = bus_mem;
	exp_q.delete();
	for (int pc = 0; pc < PROG_LEN; pc++) begin
		w    = iss_mem[pc];
		a    = x[w[19:15]];
		b    = x[w[24:20]];
		imm  = w[5] ? {{20{w[31]}}, w[31:25], w[11:7]} : {{20{w[31]}}, w[31:20]};
		addr = a + imm;
		lane = iss_mem[addr[13:2]] >> (8 * addr[1:0]);
		v    = '0;
		wr   = 1'b1;
		case (w[6:0])
			7'b0110111: v = {w[31:12], 12'h000};
			7'b0010011: v = alu_ref(w[14:12], w[14:12] == 3'd5 && w[30], a, imm);
			7'b0110011: v = alu_ref(w[14:12], w[30], a, b);
			7'b0000011: begin
				case (w[14:12])
					3'd0:    v = {{24{lane[7]}}, lane[7:0]};
					3'd1:    v = {{16{lane[15]}}, lane[15:0]};
					3'd4:    v = {24'h00_0000, lane[7:0]};
					3'd5:    v = {16'h0000, lane[15:0]};
					default: v = lane;
				endcase
			end
			7'b0100011: begin
				wr     = 1'b0;
				e.addr = addr;
				e.size = {1'b0, w[13:12]};
				e.data = replicate_lanes(b, w[13:12]);
				exp_q.push_back(e);
				iss_mem[addr[13:2]] = merge_lanes(iss_mem[addr[13:2]], e.data, addr, w[13:12]);
			end
			default: wr = 1'b0;
		endcase
		if (wr && w[11:7] != 5'd0) begin
			x[w[11:7]] = v;
		end
	end
endtask

`endif

/* sim/tb_revive_core.sv */
// Testbench for the core: AHB-lite memory with random wait states, checked against a reference model
`timescale 1ns/100ps
`default_nettype none

module tb_revive_core;
	import revive_pkg::*;

	localparam int CLK_PERIOD = 100;

	typedef struct packed {
		logic [1:0]  trans;
		logic [31:0] addr;
		logic        write;
		logic [2:0]  size;
	} aphase_t;

	logic        clk;
	logic        rst_n;
	logic        hready;
	logic [31:0] hrdata;
	logic [31:0] haddr;
	logic        hwrite;
	htrans_e     htrans;
	hsize_e      hsize;
	logic [2:0]  hburst;
	logic [3:0]  hprot;
	logic        hmastlock;
	logic [31:0] hwdata;

	// Slave state, owned by the bus process
	aphase_t     ap;
	aphase_t     last_ap;
	aphase_t     dp;
	int          wait_left;
	logic        held;
	logic        started;
	logic [31:0] next_fetch;
	int          fetch_count;
	int          store_count;
	int          error_count;

	`include "tb_revive_model.svh"

	localparam int TIMEOUT_CYCLES = N_RANDOM * 4 * 3 + 400;

	revive_core #(
		.RESET_VECTOR(32'h0000_0000)
	) i_revive_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.hready_i    (hready),
		.hrdata_i    (hrdata),
		.haddr_o     (haddr),
		.hwrite_o    (hwrite),
		.htrans_o    (htrans),
		.hsize_o     (hsize),
		.hburst_o    (hburst),
		.hprot_o     (hprot),
		.hmastlock_o (hmastlock),
		.hwdata_o    (hwdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_store(input aphase_t t, input logic [31:0] data);
		store_t e;
		if (store_count >= exp_q.size()) begin
			error_count++;
			$display("Unexpected extra store at %0t to address %h", $time, t.addr);
		end else begin
			e = exp_q[store_count];
			if (t.addr != e.addr || t.size != e.size || data != e.data) begin
				error_count++;
				$display("MISMATCH at %0t: store %0d addr %h size %0d data %h", $time,
					store_count, t.addr, t.size, data);
				$display("         expected addr %h size %0d data %h", e.addr, e.size, e.data);
			end
		end
		store_count++;
	endtask

	task automatic finish_data_phase();
		if (dp.trans == HTRANS_NONSEQ) begin
			if (dp.write) begin
				check_store(dp, hwdata);
				bus_mem[dp.addr[13:2]] = merge_lanes(bus_mem[dp.addr[13:2]], hwdata, dp.addr,
					dp.size[1:0]);
			end else begin
				hrdata <= bus_mem[dp.addr[13:2]];
			end
		end
	endtask

	task automatic accept_address(input aphase_t t);
		// Program lives below the data region, so low reads are fetches
		if (!t.write && t.addr < DATA_BASE) begin
			if (t.addr != next_fetch || t.size != HSIZE_WORD) begin
				error_count++;
				$display("MISMATCH at %0t: fetch addr %h size %0d, expected addr %h word",
					$time, t.addr, t.size, next_fetch);
			end
			next_fetch = next_fetch + 32'd4;
			fetch_count++;
		end
		wait_left = int'(rand32() % 3);
	endtask

	// ==================================================
	// AHB-lite slave
	// ==================================================

	always @(negedge clk) begin
		ap.trans = htrans;
		ap.addr  = haddr;
		ap.write = hwrite;
		ap.size  = hsize;
		if (hburst != 3'b000 || hprot != 4'b0011 || hmastlock != 1'b0) begin
			error_count++;
			$display("MISMATCH at %0t: HBURST %h HPROT %h HMASTLOCK %b", $time, hburst, hprot,
				hmastlock);
		end
		if (!rst_n) begin
			if (htrans != HTRANS_IDLE) begin
				error_count++;
				$display("MISMATCH at %0t: HTRANS %0d during reset", $time, htrans);
			end
		end else begin
			if (!started) begin
				started = 1'b1;
				if (ap.trans != HTRANS_NONSEQ || ap.addr != 32'h0 || ap.write ||
					ap.size != HSIZE_WORD) begin
					error_count++;
					$display("MISMATCH at %0t: first cycle after reset is not a word fetch at 0",
						$time);
				end
			end
			if (held && last_ap.trans == HTRANS_NONSEQ && ap != last_ap) begin
				error_count++;
				$display("MISMATCH at %0t: address phase changed from %h to %h while stalled",
					$time, last_ap, ap);
			end
			if (wait_left > 0) begin
				wait_left--;
				held = 1'b1;
				hready <= 1'b0;
			end else begin
				held = 1'b0;
				hready <= 1'b1;
				finish_data_phase();
				if (ap.trans == HTRANS_NONSEQ) begin
					accept_address(ap);
				end
				dp = ap;
			end
			last_ap = ap;
		end
	end

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		clk         = 1'b0;
		rst_n       <= 1'b0;
		hready      <= 1'b1;
		hrdata      <= '0;
		dp          = '0;
		last_ap     = '0;
		wait_left   = 0;
		held        = 1'b0;
		started     = 1'b0;
		next_fetch  = 32'h0;
		fetch_count = 0;
		store_count = 0;
		error_count = 0;
		gen_program();
		run_model();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n <= 1'b1;
		while (store_count < exp_q.size()) begin
			@(negedge clk);
		end
		// Drain so a stray late store is still seen
		repeat (20) @(negedge clk);
		if (store_count != exp_q.size()) begin
			error_count++;
			$display("MISMATCH at %0t: store count %0d, expected %0d", $time, store_count,
				exp_q.size());
		end
		$display("errors %0d, stores %0d of %0d, fetches %0d", error_count, store_count,
			exp_q.size(), fetch_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(CLK_PERIOD * TIMEOUT_CYCLES);
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+sim
common/revive_pkg.sv
core/revive_fetch.sv
core/revive_decode.sv
core/revive_regfile.sv
core/revive_execute.sv
core/revive_mem_stage.sv
src/revive_core.sv
sim/tb_revive_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module tb_revive_core -f sources.f --Mdir build
	./build/Vtb_revive_core | tee /dev/stderr | grep -q ">>> PASS"

clean:
	rm -rf build
